// File: verilog/ppi_config.svh
`ifndef PPI_CONFIG_SVH
`define PPI_CONFIG_SVH

// Register addresses
`define PPI_ADR_PORT_A      2'd0
`define PPI_ADR_PORT_B      2'd1
`define PPI_ADR_PORT_C      2'd2
`define PPI_ADR_CTRL        2'd3

// Control word bits
`define PPI_CTRL_MODE_SET   7
`define PPI_CTRL_GA_MODE    5
`define PPI_CTRL_PA_IN      4
`define PPI_CTRL_PCU_IN     3
`define PPI_CTRL_GB_MODE    2
`define PPI_CTRL_PB_IN      1
`define PPI_CTRL_PCL_IN     0

// Port C handshake bits
`define PPI_PC_INTR_A       3'd3
`define PPI_PC_STB_A        3'd4
`define PPI_PC_IBF_A        3'd5
`define PPI_PC_ACK_A        3'd6
`define PPI_PC_OBF_A        3'd7
`define PPI_PC_INTR_B       3'd0
`define PPI_PC_IBFOBF_B     3'd1
`define PPI_PC_STBACK_B     3'd2

`endif

// File: verilog/ppi_pkg.sv
package ppi_pkg;

    // Decoded control word, 1 means input
    typedef struct packed {
        logic group_a_mode;
        logic port_a_in;
        logic pc_upper_in;
        logic group_b_mode;
        logic port_b_in;
        logic pc_lower_in;
    } ppi_ctrl_t;

    // Single-cycle CPU events
    typedef struct packed {
        logic       wr_a;
        logic       rd_a;
        logic       wr_b;
        logic       rd_b;
        logic       wr_c;
        logic       bsr;
        logic       mode_set;
        logic [7:0] data;
    } ppi_event_t;

    // Handshake status of one group
    typedef struct packed {
        logic intr;
        logic ibf;
        logic obf_n;
    } ppi_hs_t;

    typedef struct packed {
        logic [7:0] out;
        logic [7:0] oe;
    } ppi_pins_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [1:0] adr;
        logic [7:0] dat;
    } ppi_wb_req_t;

endpackage

// File: verilog/ppi_bus_regs.sv
`timescale 1ns/1ps

`include "ppi_config.svh"

module ppi_bus_regs import ppi_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  ppi_wb_req_t wb_req,
    output logic [7:0]  wb_dat_r,
    output logic        wb_ack,
    output ppi_ctrl_t   ctrl,
    output ppi_event_t  evt,
    input  logic [7:0]  rd_a,
    input  logic [7:0]  rd_b,
    input  logic [7:0]  rd_c
);

    logic access;
    logic wr_hit;
    logic rd_hit;
    logic ctrl_wr;

    // New access only while no ack is pending
    assign access  = wb_req.cyc && wb_req.stb && !wb_ack;
    assign wr_hit  = access && wb_req.we;
    assign rd_hit  = access && !wb_req.we;
    assign ctrl_wr = wr_hit && (wb_req.adr == `PPI_ADR_CTRL);

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    // Events line up with ack
    always_ff @(posedge clock) begin
        if (access) begin
            evt.data <= wb_req.dat;
        end
        if (reset) begin
            evt.wr_a     <= 1'b0;
            evt.rd_a     <= 1'b0;
            evt.wr_b     <= 1'b0;
            evt.rd_b     <= 1'b0;
            evt.wr_c     <= 1'b0;
            evt.bsr      <= 1'b0;
            evt.mode_set <= 1'b0;
        end else begin
            evt.wr_a     <= wr_hit && (wb_req.adr == `PPI_ADR_PORT_A);
            evt.rd_a     <= rd_hit && (wb_req.adr == `PPI_ADR_PORT_A);
            evt.wr_b     <= wr_hit && (wb_req.adr == `PPI_ADR_PORT_B);
            evt.rd_b     <= rd_hit && (wb_req.adr == `PPI_ADR_PORT_B);
            evt.wr_c     <= wr_hit && (wb_req.adr == `PPI_ADR_PORT_C);
            evt.bsr      <= ctrl_wr && !wb_req.dat[`PPI_CTRL_MODE_SET];
            evt.mode_set <= ctrl_wr && wb_req.dat[`PPI_CTRL_MODE_SET];
        end
    end

    // Control word, bit 6 has no meaning without mode 2
    always_ff @(posedge clock) begin
        if (reset) begin
            ctrl <= '{group_a_mode: 1'b0, port_a_in: 1'b1, pc_upper_in: 1'b1,
                      group_b_mode: 1'b0, port_b_in: 1'b1, pc_lower_in: 1'b1};
        end else if (ctrl_wr && wb_req.dat[`PPI_CTRL_MODE_SET]) begin
            ctrl.group_a_mode <= wb_req.dat[`PPI_CTRL_GA_MODE];
            ctrl.port_a_in    <= wb_req.dat[`PPI_CTRL_PA_IN];
            ctrl.pc_upper_in  <= wb_req.dat[`PPI_CTRL_PCU_IN];
            ctrl.group_b_mode <= wb_req.dat[`PPI_CTRL_GB_MODE];
            ctrl.port_b_in    <= wb_req.dat[`PPI_CTRL_PB_IN];
            ctrl.pc_lower_in  <= wb_req.dat[`PPI_CTRL_PCL_IN];
        end
    end

    // Read data valid in the ack cycle
    always_ff @(posedge clock) begin
        if (rd_hit) begin
            case (wb_req.adr)
                `PPI_ADR_PORT_A: wb_dat_r <= rd_a;
                `PPI_ADR_PORT_B: wb_dat_r <= rd_b;
                `PPI_ADR_PORT_C: wb_dat_r <= rd_c;
                default:         wb_dat_r <= {2'b10, ctrl};
            endcase
        end
    end

    ack_follows_req: assert property (@(posedge clock) disable iff (reset)
        wb_ack |-> $past(wb_req.cyc && wb_req.stb));

    ack_single_cycle: assert property (@(posedge clock) disable iff (reset)
        wb_ack |=> !wb_ack);

endmodule

// File: verilog/ppi_handshake.sv
`timescale 1ns/1ps

module ppi_handshake import ppi_pkg::*; (
    input  logic    clock,
    input  logic    reset,
    input  logic    mode1,
    input  logic    dir_in,
    input  logic    stb_ack_n,
    input  logic    inte,
    input  logic    cpu_wr,
    input  logic    cpu_rd,
    input  logic    mode_set,
    output ppi_hs_t hs
);

    ppi_hs_t hs_next;

    always_comb begin
        hs_next = hs;
        if (dir_in) begin
            // Strobed input, CPU read empties the buffer
            hs_next.obf_n = 1'b1;
            if (!stb_ack_n)
                hs_next.ibf = 1'b1;
            if (stb_ack_n && hs.ibf)
                hs_next.intr = 1'b1;
            if (cpu_rd) begin
                hs_next.ibf  = 1'b0;
                hs_next.intr = 1'b0;
            end
        end else begin
            // Output, ACK from the device empties the buffer
            hs_next.ibf = 1'b0;
            if (stb_ack_n && hs.obf_n)
                hs_next.intr = 1'b1;
            if (cpu_wr) begin
                hs_next.obf_n = 1'b0;
                hs_next.intr  = 1'b0;
            end
            if (!stb_ack_n)
                hs_next.obf_n = 1'b1;
        end
        if (!inte)
            hs_next.intr = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (reset || mode_set || !mode1) begin
            hs <= '{intr: 1'b0, ibf: 1'b0, obf_n: 1'b1};
        end else begin
            hs <= hs_next;
        end
    end

    intr_needs_inte: assert property (@(posedge clock) disable iff (reset)
        !inte |=> !hs.intr);

endmodule

// File: verilog/ppi_data_port.sv
`timescale 1ns/1ps

module ppi_data_port import ppi_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       mode1,
    input  logic       dir_in,
    input  logic       wr,
    input  logic [7:0] data,
    input  logic       stb_n,
    input  logic [7:0] pin_in,
    output ppi_pins_t  pins,
    output logic [7:0] rd_val
);

    logic [7:0] out_reg;
    logic [7:0] in_latch;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_reg <= 8'h00;
        end else if (wr) begin
            out_reg <= data;
        end
    end

    // Transparent while the strobe is low
    always_ff @(posedge clock) begin
        if (reset) begin
            in_latch <= 8'h00;
        end else if (mode1 && dir_in && !stb_n) begin
            in_latch <= pin_in;
        end
    end

    assign pins.out = out_reg;
    assign pins.oe  = {8{!dir_in}};

    always_comb begin
        if (!dir_in) begin
            rd_val = out_reg;
        end else if (mode1) begin
            rd_val = in_latch;
        end else begin
            rd_val = pin_in;
        end
    end

endmodule

// File: verilog/ppi_port_c.sv
`timescale 1ns/1ps

`include "ppi_config.svh"

module ppi_port_c import ppi_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  ppi_ctrl_t  ctrl,
    input  ppi_event_t evt,
    input  logic [7:0] pin_in,
    input  ppi_hs_t    hs_a,
    input  ppi_hs_t    hs_b,
    output ppi_pins_t  pins,
    output logic [7:0] rd_val,
    output logic       stb_ack_a_n,
    output logic       stb_ack_b_n,
    output logic       inte_a,
    output logic       inte_b
);

    logic [7:0] pc_reg;
    logic [7:0] pc_oe;
    logic [7:0] pc_drv;
    logic [2:0] hs_in_a;

    // STB A or ACK A depending on port A direction
    assign hs_in_a = ctrl.port_a_in ? `PPI_PC_STB_A : `PPI_PC_ACK_A;

    always_comb begin
        pc_oe[7:4] = {4{!ctrl.pc_upper_in}};
        pc_oe[3:0] = {4{!ctrl.pc_lower_in}};
        if (ctrl.group_b_mode) begin
            pc_oe[`PPI_PC_INTR_B]   = 1'b1;
            pc_oe[`PPI_PC_IBFOBF_B] = 1'b1;
            pc_oe[`PPI_PC_STBACK_B] = 1'b0;
        end
        // Group A takes PC3 over from the lower nibble
        if (ctrl.group_a_mode) begin
            pc_oe[`PPI_PC_INTR_A] = 1'b1;
            pc_oe[hs_in_a]        = 1'b0;
            if (ctrl.port_a_in) begin
                pc_oe[`PPI_PC_IBF_A] = 1'b1;
            end else begin
                pc_oe[`PPI_PC_OBF_A] = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || evt.mode_set) begin
            pc_reg <= 8'h00;
        end else if (evt.wr_c) begin
            pc_reg <= evt.data;
        end else if (evt.bsr) begin
            pc_reg[evt.data[3:1]] <= evt.data[0];
        end
    end

    // Handshake status replaces the register bits it owns
    always_comb begin
        pc_drv = pc_reg;
        if (ctrl.group_b_mode) begin
            pc_drv[`PPI_PC_INTR_B]   = hs_b.intr;
            pc_drv[`PPI_PC_IBFOBF_B] = ctrl.port_b_in ? hs_b.ibf : hs_b.obf_n;
        end
        if (ctrl.group_a_mode) begin
            pc_drv[`PPI_PC_INTR_A] = hs_a.intr;
            if (ctrl.port_a_in) begin
                pc_drv[`PPI_PC_IBF_A] = hs_a.ibf;
            end else begin
                pc_drv[`PPI_PC_OBF_A] = hs_a.obf_n;
            end
        end
    end

    assign pins.out = pc_drv;
    assign pins.oe  = pc_oe;

    assign rd_val = (pc_drv & pc_oe) | (pin_in & ~pc_oe);

    // Idle high outside mode 1
    assign stb_ack_a_n = ctrl.group_a_mode ? pin_in[hs_in_a] : 1'b1;
    assign stb_ack_b_n = ctrl.group_b_mode ? pin_in[`PPI_PC_STBACK_B] : 1'b1;

    // INTE lives in the strobe/ack bit of the register
    assign inte_a = pc_reg[hs_in_a];
    assign inte_b = pc_reg[`PPI_PC_STBACK_B];

    strobe_a_undriven: assert property (@(posedge clock) disable iff (reset)
        ctrl.group_a_mode |-> !pins.oe[hs_in_a]);

    strobe_b_undriven: assert property (@(posedge clock) disable iff (reset)
        ctrl.group_b_mode |-> !pins.oe[`PPI_PC_STBACK_B]);

endmodule

// File: verilog/ppi_top.sv
`timescale 1ns/1ps

module ppi_top import ppi_pkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  ppi_wb_req_t wb_req,
    output logic [7:0]  wb_dat_r,
    output logic        wb_ack,
    input  logic [7:0]  pa_in,
    output ppi_pins_t   pa_pins,
    input  logic [7:0]  pb_in,
    output ppi_pins_t   pb_pins,
    input  logic [7:0]  pc_in,
    output ppi_pins_t   pc_pins
);

    ppi_ctrl_t  ctrl;
    ppi_event_t evt;
    ppi_hs_t    hs_a;
    ppi_hs_t    hs_b;
    logic [7:0] rd_a;
    logic [7:0] rd_b;
    logic [7:0] rd_c;
    logic       stb_ack_a_n;
    logic       stb_ack_b_n;
    logic       inte_a;
    logic       inte_b;

    ppi_bus_regs i_bus_regs (
        .clock    (clock),
        .reset    (reset),
        .wb_req   (wb_req),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ctrl     (ctrl),
        .evt      (evt),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .rd_c     (rd_c)
    );

    ppi_data_port i_port_a (
        .clock  (clock),
        .reset  (reset),
        .mode1  (ctrl.group_a_mode),
        .dir_in (ctrl.port_a_in),
        .wr     (evt.wr_a),
        .data   (evt.data),
        .stb_n  (stb_ack_a_n),
        .pin_in (pa_in),
        .pins   (pa_pins),
        .rd_val (rd_a)
    );

    ppi_data_port i_port_b (
        .clock  (clock),
        .reset  (reset),
        .mode1  (ctrl.group_b_mode),
        .dir_in (ctrl.port_b_in),
        .wr     (evt.wr_b),
        .data   (evt.data),
        .stb_n  (stb_ack_b_n),
        .pin_in (pb_in),
        .pins   (pb_pins),
        .rd_val (rd_b)
    );

    ppi_port_c i_port_c (
        .clock       (clock),
        .reset       (reset),
        .ctrl        (ctrl),
        .evt         (evt),
        .pin_in      (pc_in),
        .hs_a        (hs_a),
        .hs_b        (hs_b),
        .pins        (pc_pins),
        .rd_val      (rd_c),
        .stb_ack_a_n (stb_ack_a_n),
        .stb_ack_b_n (stb_ack_b_n),
        .inte_a      (inte_a),
        .inte_b      (inte_b)
    );

    ppi_handshake i_hs_a (
        .clock     (clock),
        .reset     (reset),
        .mode1     (ctrl.group_a_mode),
        .dir_in    (ctrl.port_a_in),
        .stb_ack_n (stb_ack_a_n),
        .inte      (inte_a),
        .cpu_wr    (evt.wr_a),
        .cpu_rd    (evt.rd_a),
        .mode_set  (evt.mode_set),
        .hs        (hs_a)
    );

    ppi_handshake i_hs_b (
        .clock     (clock),
        .reset     (reset),
        .mode1     (ctrl.group_b_mode),
        .dir_in    (ctrl.port_b_in),
        .stb_ack_n (stb_ack_b_n),
        .inte      (inte_b),
        .cpu_wr    (evt.wr_b),
        .cpu_rd    (evt.rd_b),
        .mode_set  (evt.mode_set),
        .hs        (hs_b)
    );

endmodule

// File: tests/ppi_tb.sv
`timescale 1ns/1ps

`include "ppi_config.svh"

module ppi_tb import ppi_pkg::*; ();

    // Reads plus writes of each test section
    localparam int planned_txn = 3 + 8 * 7 + (1 + 16 * 2 + 2) + 6 + 6;

    logic        clock;
    logic        reset;
    ppi_wb_req_t wb_req;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;
    logic [7:0]  pa_in;
    logic [7:0]  pb_in;
    logic [7:0]  pc_in;
    ppi_pins_t   pa_pins;
    ppi_pins_t   pb_pins;
    ppi_pins_t   pc_pins;

    logic [31:0] lfsr;
    int          err_count;

    // Reference model state
    ppi_ctrl_t   m_ctrl;
    logic [7:0]  m_pa_reg;
    logic [7:0]  m_pb_reg;
    logic [7:0]  m_pc_reg;
    logic [7:0]  m_pa_latch;
    ppi_hs_t     m_hs_a;
    ppi_hs_t     m_hs_b;

    ppi_top i_ppi_top (
        .clock    (clock),
        .reset    (reset),
        .wb_req   (wb_req),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .pa_in    (pa_in),
        .pa_pins  (pa_pins),
        .pb_in    (pb_in),
        .pb_pins  (pb_pins),
        .pc_in    (pc_in),
        .pc_pins  (pc_pins)
    );

    always #4 clock = ~clock;

    initial begin
        repeat (planned_txn * 40) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", planned_txn * 40);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    // Galois LFSR, one step per bit
    function automatic logic rand_bit();
        logic lsb;
        lsb = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb)
            lfsr = lfsr ^ 32'h80200003;
        return lsb;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] value;
        for (int i = 0; i < 8; i++)
            value[i] = rand_bit();
        return value;
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            err_count++;
            $display("Fail %s: actual 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Some tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic logic [7:0] exp_pc_oe();
        logic [7:0] oe;
        oe = {{4{~m_ctrl.pc_upper_in}}, {4{~m_ctrl.pc_lower_in}}};
        if (m_ctrl.group_b_mode) begin
            oe[`PPI_PC_INTR_B]   = 1'b1;
            oe[`PPI_PC_IBFOBF_B] = 1'b1;
            oe[`PPI_PC_STBACK_B] = 1'b0;
        end
        if (m_ctrl.group_a_mode) begin
            oe[`PPI_PC_INTR_A] = 1'b1;
            if (m_ctrl.port_a_in) begin
                oe[`PPI_PC_STB_A] = 1'b0;
                oe[`PPI_PC_IBF_A] = 1'b1;
            end else begin
                oe[`PPI_PC_ACK_A] = 1'b0;
                oe[`PPI_PC_OBF_A] = 1'b1;
            end
        end
        return oe;
    endfunction

    function automatic logic [7:0] exp_pc_drv();
        logic [7:0] drv;
        drv = m_pc_reg;
        if (m_ctrl.group_b_mode) begin
            drv[`PPI_PC_INTR_B]   = m_hs_b.intr;
            drv[`PPI_PC_IBFOBF_B] = m_ctrl.port_b_in ? m_hs_b.ibf : m_hs_b.obf_n;
        end
        if (m_ctrl.group_a_mode) begin
            drv[`PPI_PC_INTR_A] = m_hs_a.intr;
            if (m_ctrl.port_a_in)
                drv[`PPI_PC_IBF_A] = m_hs_a.ibf;
            else
                drv[`PPI_PC_OBF_A] = m_hs_a.obf_n;
        end
        return drv;
    endfunction

    function automatic logic [7:0] exp_c_read();
        logic [7:0] oe;
        oe = exp_pc_oe();
        return (exp_pc_drv() & oe) | (pc_in & ~oe);
    endfunction

    // Mode 0 only
    function automatic logic [7:0] exp_ab_read(input logic [7:0] out_reg,
                                               input logic [7:0] pin, input logic dir_in);
        return dir_in ? pin : out_reg;
    endfunction

    function automatic void model_mode_set(input logic [7:0] d);
        m_ctrl.group_a_mode = d[`PPI_CTRL_GA_MODE];
        m_ctrl.port_a_in    = d[`PPI_CTRL_PA_IN];
        m_ctrl.pc_upper_in  = d[`PPI_CTRL_PCU_IN];
        m_ctrl.group_b_mode = d[`PPI_CTRL_GB_MODE];
        m_ctrl.port_b_in    = d[`PPI_CTRL_PB_IN];
        m_ctrl.pc_lower_in  = d[`PPI_CTRL_PCL_IN];
        m_pc_reg = 8'h00;
        m_hs_a   = '{intr: 1'b0, ibf: 1'b0, obf_n: 1'b1};
        m_hs_b   = '{intr: 1'b0, ibf: 1'b0, obf_n: 1'b1};
    endfunction

    // One Wishbone classic access with ack timing checks
    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [7:0] dat,
                             output logic [7:0] rdata);
        int n;
        @(posedge clock);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(negedge clock);
        n = 1;
        while (!wb_ack && n < 8) begin
            @(negedge clock);
            n++;
        end
        check("wb_ack latency", 32'(n), 32'd2);
        rdata = wb_dat_r;
        @(posedge clock);
        wb_req <= '0;
        @(negedge clock);
        check("wb_ack length", 32'(wb_ack), 32'd0);
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [7:0] dat);
        logic [7:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [7:0] dat);
        wb_access(1'b0, adr, 8'h00, dat);
    endtask

    task automatic read_check(input logic [1:0] adr, input logic [7:0] expected,
                              input string name);
        logic [7:0] d;
        wb_read(adr, d);
        check(name, 32'(d), 32'(expected));
    endtask

    task automatic write_ctrl(input logic [7:0] d);
        wb_write(`PPI_ADR_CTRL, d);
        if (d[`PPI_CTRL_MODE_SET])
            model_mode_set(d);
        else
            m_pc_reg[d[3:1]] = d[0];
    endtask

    task automatic write_port(input logic [1:0] adr, input logic [7:0] d);
        wb_write(adr, d);
        case (adr)
            `PPI_ADR_PORT_A: m_pa_reg = d;
            `PPI_ADR_PORT_B: m_pb_reg = d;
            default:         m_pc_reg = d;
        endcase
    endtask

    task automatic drive_pins(input logic [7:0] a, input logic [7:0] b, input logic [7:0] c);
        @(posedge clock);
        pa_in <= a;
        pb_in <= b;
        pc_in <= c;
        @(negedge clock);
    endtask

    task automatic check_pins();
        logic [7:0] a_oe;
        logic [7:0] b_oe;
        logic [7:0] c_oe;
        a_oe = {8{~m_ctrl.port_a_in}};
        b_oe = {8{~m_ctrl.port_b_in}};
        c_oe = exp_pc_oe();
        check("pa_pins.oe", 32'(pa_pins.oe), 32'(a_oe));
        check("pa_pins.out", 32'(pa_pins.out & a_oe), 32'(m_pa_reg & a_oe));
        check("pb_pins.oe", 32'(pb_pins.oe), 32'(b_oe));
        check("pb_pins.out", 32'(pb_pins.out & b_oe), 32'(m_pb_reg & b_oe));
        check("pc_pins.oe", 32'(pc_pins.oe), 32'(c_oe));
        check("pc_pins.out", 32'(pc_pins.out & c_oe), 32'(exp_pc_drv() & c_oe));
    endtask

    initial begin
        logic [7:0] cw;
        logic [7:0] data;
        logic       inte;
        clock = 1'b0;
        reset = 1'b1;
        wb_req = '0;
        pa_in = 8'h00;
        pb_in = 8'h00;
        pc_in = 8'h00;
        lfsr = 32'hdaa5f66d;
        err_count = 0;
        model_mode_set(8'h9b);
        m_pa_reg = 8'h00;
        m_pb_reg = 8'h00;
        m_pa_latch = 8'h00;
        repeat (2) @(posedge clock);
        reset <= 1'b0;

        // Reset state and bus timing
        @(negedge clock);
        check("wb_ack", 32'(wb_ack), 32'd0);
        check_pins();
        drive_pins(rand_byte(), rand_byte(), rand_byte());
        read_check(`PPI_ADR_PORT_A, pa_in, "port A read after reset");
        read_check(`PPI_ADR_PORT_B, pb_in, "port B read after reset");
        read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read after reset");

        // Mode 0 transfers
        for (int i = 0; i < 8; i++) begin
            cw = {1'b1, rand_bit(), 1'b0, rand_bit(), rand_bit(), 1'b0, rand_bit(), rand_bit()};
            write_ctrl(cw);
            write_port(`PPI_ADR_PORT_A, rand_byte());
            write_port(`PPI_ADR_PORT_B, rand_byte());
            write_port(`PPI_ADR_PORT_C, rand_byte());
            drive_pins(rand_byte(), rand_byte(), rand_byte());
            check_pins();
            read_check(`PPI_ADR_PORT_A, exp_ab_read(m_pa_reg, pa_in, m_ctrl.port_a_in),
                       "port A read");
            read_check(`PPI_ADR_PORT_B, exp_ab_read(m_pb_reg, pb_in, m_ctrl.port_b_in),
                       "port B read");
            read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read");
        end

        // Port C bit set/reset
        cw = {1'b1, rand_bit(), 1'b0, rand_bit(), rand_bit(), 1'b0, rand_bit(), rand_bit()};
        // Keep at least one nibble of port C driven
        if (cw[`PPI_CTRL_PCU_IN] && cw[`PPI_CTRL_PCL_IN])
            cw[`PPI_CTRL_PCL_IN] = 1'b0;
        write_ctrl(cw);
        drive_pins(rand_byte(), rand_byte(), rand_byte());
        for (int i = 0; i < 16; i++) begin
            if (rand_bit())
                write_port(`PPI_ADR_PORT_C, rand_byte());
            else
                write_ctrl(rand_byte() & 8'h7f);
            check_pins();
            read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read after bsr");
        end
        // Both nibbles driven so the cleared register shows on every bit
        write_ctrl(cw & ~8'h09);
        check_pins();
        read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read after mode set");

        // Mode 1 input on port A, STB idle high
        drive_pins(rand_byte(), rand_byte(), rand_byte() | 8'h10);
        cw = {4'b1011, rand_bit(), 1'b0, rand_bit(), rand_bit()};
        write_ctrl(cw);
        write_ctrl(8'h09);
        check_pins();
        read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read before STB A");
        data = rand_byte();
        @(posedge clock);
        pa_in <= data;
        pc_in <= pc_in & ~8'h10;
        repeat (3) @(posedge clock);
        pc_in <= pc_in | 8'h10;
        repeat (2) @(posedge clock);
        pa_in <= rand_byte();
        @(negedge clock);
        m_pa_latch = data;
        m_hs_a.ibf = 1'b1;
        m_hs_a.intr = 1'b1;
        check_pins();
        read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read after STB A");
        read_check(`PPI_ADR_PORT_A, m_pa_latch, "port A latched read");
        m_hs_a.ibf = 1'b0;
        m_hs_a.intr = 1'b0;
        read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read after port A read");

        // Mode 1 output on port B, ACK idle high
        drive_pins(rand_byte(), rand_byte(), rand_byte() | 8'h04);
        cw = {3'b100, rand_bit(), rand_bit(), 2'b10, rand_bit()};
        write_ctrl(cw);
        inte = rand_bit();
        write_ctrl({7'b0000_010, inte});
        // Empty buffer requests data when enabled
        m_hs_b.intr = inte;
        read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read with INTE B");
        write_port(`PPI_ADR_PORT_B, rand_byte());
        m_hs_b.obf_n = 1'b0;
        m_hs_b.intr = 1'b0;
        check_pins();
        read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read after port B write");
        @(posedge clock);
        pc_in <= pc_in & ~8'h04;
        repeat (2) @(posedge clock);
        pc_in <= pc_in | 8'h04;
        repeat (2) @(posedge clock);
        @(negedge clock);
        m_hs_b.obf_n = 1'b1;
        m_hs_b.intr = inte;
        check_pins();
        read_check(`PPI_ADR_PORT_C, exp_c_read(), "port C read after ACK B");

        if (err_count == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            $display("Some tests failed");
            $fatal(1, "errors were counted");
        end
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/ppi_pkg.sv
verilog/ppi_bus_regs.sv
verilog/ppi_handshake.sv
verilog/ppi_data_port.sv
verilog/ppi_port_c.sv
verilog/ppi_top.sv
tests/ppi_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ppi_tb -f flist.f -Mdir obj_dir -o ppi_sim
./obj_dir/ppi_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
